// File: Bender.yml
package:
  name: backend_commit

sources:
  - verilog/core_cfg_pkg.sv
  - verilog/csr_pkg.sv
  - verilog/redirect_ctrl.sv
  - verilog/csr_file.sv
  - verilog/regfile.sv
  - verilog/commit_trace.sv
  - verilog/backend_commit_top.sv
  - target: test
    files:
      - verif/tb_backend_commit.sv

// File: project.f
verilog/core_cfg_pkg.sv
verilog/csr_pkg.sv
verilog/redirect_ctrl.sv
verilog/csr_file.sv
verilog/regfile.sv
verilog/commit_trace.sv
verilog/backend_commit_top.sv
verif/tb_backend_commit.sv

// File: verif/tb_backend_commit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_backend_commit;
    import core_cfg_pkg::*;
    import csr_pkg::*;

    localparam int NUM_READ_PORTS = 4;
    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 5;
    // Regs, trace, exception, ertn, priority, CSR writes
    localparam int TEST_CYCLES    = 16 + 8 + 10 + 6 + 14 + 6;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 50;

    logic                                      clk;
    logic                                      reset_i;
    commit_slot_t [COMMIT_WIDTH-1:0]           commit_i;
    excp_event_t                               excp_i;
    branch_req_t [COMMIT_WIDTH-1:0]            branch_i;
    logic                                      ex_stall_i;
    csr_wr_t [COMMIT_WIDTH-1:0]                csr_wr_i;
    logic [CSR_ADDR_W-1:0]                     csr_raddr_i;
    logic [NUM_READ_PORTS-1:0][REG_ADDR_W-1:0] reg_raddr_i;
    redirect_t                                 redirect_o;
    logic [XLEN-1:0]                           csr_rdata_o;
    logic [NUM_READ_PORTS-1:0][XLEN-1:0]       reg_rdata_o;
    commit_slot_t [COMMIT_WIDTH-1:0]           trace_o;

    // Reference model state
    logic [XLEN-1:0]       ref_regs [32];
    logic [2:0]            ref_crmd;  // {ie, plv}
    logic [2:0]            ref_prmd;
    logic [ECODE_W-1:0]    ref_ecode;
    logic [ESUBCODE_W-1:0] ref_esubcode;
    logic [XLEN-1:0]       ref_era;
    logic [XLEN-1:0]       ref_eentry;
    logic [XLEN-1:0]       ref_tlbrentry;
    logic [XLEN-1:0]       ref_save0;

    integer seed;
    int     error_count;
    int     check_count;

    backend_commit_top #(
        .NUM_READ_PORTS(NUM_READ_PORTS)
    ) u_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .commit_i   (commit_i),
        .excp_i     (excp_i),
        .branch_i   (branch_i),
        .ex_stall_i (ex_stall_i),
        .csr_wr_i   (csr_wr_i),
        .csr_raddr_i(csr_raddr_i),
        .reg_raddr_i(reg_raddr_i),
        .redirect_o (redirect_o),
        .csr_rdata_o(csr_rdata_o),
        .reg_rdata_o(reg_rdata_o),
        .trace_o    (trace_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("** Error: %s expected %0h, got %0h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;  // Drive just after the edge
    endtask

    function automatic commit_slot_t make_slot(input logic valid, input logic we,
                                               input logic [4:0] waddr, input logic [31:0] wdata,
                                               input logic [31:0] pc, input logic [2:0] ftq);
        commit_slot_t c;
        c.valid  = valid;
        c.we     = we;
        c.waddr  = waddr;
        c.wdata  = wdata;
        c.pc     = pc;
        c.ftq_id = ftq;
        return c;
    endfunction

    function automatic excp_event_t make_event(input logic excp, input logic ertn,
                                               input logic idle, input logic refetch,
                                               input logic tlbrefill, input logic [5:0] ecode,
                                               input logic [8:0] esub, input logic [31:0] pc,
                                               input logic [2:0] ftq);
        excp_event_t ev;
        ev = '0;
        ev.excp      = excp;
        ev.ertn      = ertn;
        ev.idle      = idle;
        ev.refetch   = refetch;
        ev.tlbrefill = tlbrefill;
        ev.ecode     = ecode;
        ev.esubcode  = esub;
        ev.pc        = pc;
        ev.ftq_id    = ftq;
        return ev;
    endfunction

    function automatic branch_req_t make_branch(input logic taken, input logic [31:0] target,
                                                input logic [2:0] ftq);
        branch_req_t b;
        b.taken  = taken;
        b.target = target;
        b.ftq_id = ftq;
        return b;
    endfunction

    function automatic csr_wr_t make_csr_wr(input logic [13:0] addr, input logic [31:0] data);
        csr_wr_t w;
        w.we   = 1'b1;
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    // Expected CSR word, LoongArch field layout
    function automatic logic [31:0] expected_csr(input logic [13:0] addr);
        case (addr)
            CSR_CRMD:      return {29'b0, ref_crmd};
            CSR_PRMD:      return {29'b0, ref_prmd};
            CSR_ESTAT:     return {1'b0, ref_esubcode, ref_ecode, 16'b0};
            CSR_ERA:       return ref_era;
            CSR_EENTRY:    return ref_eentry;
            CSR_TLBRENTRY: return ref_tlbrentry;
            CSR_SAVE0:     return ref_save0;
            default:       return 32'b0;
        endcase
    endfunction

    // Ranked flush causes, branches masked by stall
    function automatic redirect_t expected_redirect(input excp_event_t ev, input branch_req_t b0,
                                                    input branch_req_t b1, input logic stall);
        redirect_t r;
        r = '0;
        r.flush = 1'b1;
        if (ev.excp) begin
            r.next_pc = ev.tlbrefill ? ref_tlbrentry : ref_eentry;
            r.ftq_id  = ev.ftq_id;
        end else if (ev.ertn) begin
            r.next_pc = ref_era;
            r.ftq_id  = ev.ftq_id;
        end else if (ev.idle || ev.refetch) begin
            r.next_pc = ev.idle ? ev.pc : ev.pc + 32'd4;
            r.ftq_id  = ev.ftq_id;
        end else if (!stall && b0.taken) begin
            r.next_pc = b0.target;
            r.ftq_id  = b0.ftq_id;
        end else if (!stall && b1.taken) begin
            r.next_pc = b1.target;
            r.ftq_id  = b1.ftq_id;
        end else begin
            r = '0;  // No flush, no target
        end
        return r;
    endfunction

    task automatic apply_csr_write(input csr_wr_t w);
        if (w.we) begin
            case (w.addr)
                CSR_CRMD:      ref_crmd = w.data[2:0];
                CSR_PRMD:      ref_prmd = w.data[2:0];
                CSR_ERA:       ref_era = w.data;
                CSR_EENTRY:    ref_eentry = w.data & ~32'h3f;
                CSR_TLBRENTRY: ref_tlbrentry = w.data & ~32'h3f;
                CSR_SAVE0:     ref_save0 = w.data;
                default:       ;  // ESTAT and unknown addresses ignore writes
            endcase
        end
    endtask

    task automatic commit_pair(input commit_slot_t c0, input commit_slot_t c1);
        next_cycle();
        commit_i[0] = c0;
        commit_i[1] = c1;
        // Slot 1 applied last so it wins a shared index
        if (c0.valid && c0.we && c0.waddr != 5'd0) ref_regs[c0.waddr] = c0.wdata;
        if (c1.valid && c1.we && c1.waddr != 5'd0) ref_regs[c1.waddr] = c1.wdata;
        next_cycle();
        commit_i = '0;
        #10;
        check_value("trace_o[0]", c0.valid ? c0 : '0, trace_o[0]);
        check_value("trace_o[1]", c1.valid ? c1 : '0, trace_o[1]);
    endtask

    task automatic read_regs(input logic [4:0] a, input logic [4:0] b);
        reg_raddr_i[0] = a;
        reg_raddr_i[1] = b;
        reg_raddr_i[2] = 5'd0;
        reg_raddr_i[3] = a;
        #10;
        for (int p = 0; p < NUM_READ_PORTS; p++) begin
            check_value($sformatf("reg_rdata_o[%0d]", p), ref_regs[reg_raddr_i[p]],
                        reg_rdata_o[p]);
        end
    endtask

    task automatic csr_write(input csr_wr_t w0, input csr_wr_t w1);
        next_cycle();
        csr_wr_i[0] = w0;
        csr_wr_i[1] = w1;
        apply_csr_write(w0);
        apply_csr_write(w1);
        next_cycle();
        csr_wr_i = '0;
    endtask

    task automatic read_csr(input logic [13:0] addr);
        csr_raddr_i = addr;
        #10;
        check_value($sformatf("csr_rdata_o[%0h]", addr), expected_csr(addr), csr_rdata_o);
    endtask

    task automatic flush_cycle(input excp_event_t ev, input branch_req_t b0,
                               input branch_req_t b1, input logic stall);
        redirect_t exp;
        next_cycle();
        excp_i      = ev;
        branch_i[0] = b0;
        branch_i[1] = b1;
        ex_stall_i  = stall;
        exp = expected_redirect(ev, b0, b1, stall);
        #10;
        check_value("redirect_o.flush", exp.flush, redirect_o.flush);
        check_value("redirect_o.next_pc", exp.next_pc, redirect_o.next_pc);
        check_value("redirect_o.ftq_id", exp.ftq_id, redirect_o.ftq_id);
        if (ev.excp) begin
            ref_prmd     = ref_crmd;
            ref_crmd     = 3'b0;
            ref_era      = ev.pc;
            ref_ecode    = ev.ecode;
            ref_esubcode = ev.esubcode;
        end else if (ev.ertn) begin
            ref_crmd = ref_prmd;
        end
        next_cycle();
        excp_i     = '0;
        branch_i   = '0;
        ex_stall_i = 1'b0;
    endtask

    task automatic check_after_reset;
        #10;
        check_value("trace_o[0].valid", 1'b0, trace_o[0].valid);
        check_value("trace_o[1].valid", 1'b0, trace_o[1].valid);
        check_value("redirect_o.flush", 1'b0, redirect_o.flush);
        read_csr(CSR_CRMD);
        read_csr(CSR_ERA);
    endtask

    task automatic test_reg_write_read;
        logic [4:0] a;
        logic [4:0] b;
        for (int i = 0; i < 6; i++) begin
            a = 5'(1 + $unsigned($random(seed)) % 31);
            b = 5'(1 + $unsigned($random(seed)) % 31);
            commit_pair(make_slot(1'b1, 1'b1, a, $random(seed), 32'h1c00_1000 + 8 * i, 3'(i)),
                        make_slot(1'b1, 1'b1, b, $random(seed), 32'h1c00_1004 + 8 * i, 3'(i)));
            read_regs(a, b);
        end
        commit_pair(make_slot(1'b1, 1'b1, 5'd7, $random(seed), 32'h1c00_1100, 3'd6),
                    make_slot(1'b1, 1'b1, 5'd7, $random(seed), 32'h1c00_1104, 3'd6));
        read_regs(5'd7, 5'd7);
        commit_pair(make_slot(1'b1, 1'b1, 5'd0, $random(seed), 32'h1c00_1108, 3'd7),
                    make_slot(1'b1, 1'b1, 5'd9, $random(seed), 32'h1c00_110c, 3'd7));
        read_regs(5'd0, 5'd9);
    endtask

    task automatic test_trace;
        commit_pair(make_slot(1'b0, 1'b1, 5'd3, 32'hdead_beef, 32'h1c00_2000, 3'd1),
                    make_slot(1'b1, 1'b0, 5'd4, 32'h0bad_f00d, 32'h1c00_2004, 3'd1));
        commit_pair(make_slot(1'b1, 1'b1, 5'd12, $random(seed), 32'h1c00_2008, 3'd2),
                    make_slot(1'b0, 1'b1, 5'd13, 32'h1357_9bdf, 32'h1c00_200c, 3'd2));
        commit_pair('0, '0);
        commit_pair(make_slot(1'b1, 1'b1, 5'd20, $random(seed), 32'h1c00_2010, 3'd3),
                    make_slot(1'b1, 1'b1, 5'd21, $random(seed), 32'h1c00_2014, 3'd3));
    endtask

    task automatic test_exception_entry;
        csr_write(make_csr_wr(CSR_EENTRY, 32'h1c00_8000),
                  make_csr_wr(CSR_TLBRENTRY, 32'h1c00_f000));
        csr_write(make_csr_wr(CSR_CRMD, 32'h7), '0);  // plv 3, ie set
        flush_cycle(make_event(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, ECODE_SYS, 9'h0, 32'h1c00_0104, 3'd2),
                    '0, '0, 1'b0);
        read_csr(CSR_ERA);
        read_csr(CSR_ESTAT);
        read_csr(CSR_PRMD);
        read_csr(CSR_CRMD);
        csr_write(make_csr_wr(CSR_CRMD, 32'h5), '0);
        flush_cycle(make_event(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, ECODE_TLBR, 9'h1, 32'h1c00_0ac0,
                               3'd5), '0, '0, 1'b0);
        read_csr(CSR_ERA);
        read_csr(CSR_ESTAT);
        read_csr(CSR_PRMD);
        read_csr(CSR_CRMD);
    endtask

    task automatic test_ertn;
        read_csr(CSR_ERA);
        flush_cycle(make_event(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 6'h0, 9'h0, 32'h1c00_0ff0, 3'd6),
                    '0, '0, 1'b0);
        read_csr(CSR_CRMD);
        csr_write(make_csr_wr(CSR_PRMD, 32'h3), make_csr_wr(CSR_ERA, 32'h1c00_2468));
        flush_cycle(make_event(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 6'h0, 9'h0, 32'h1c00_0ff4, 3'd1),
                    '0, '0, 1'b0);
        read_csr(CSR_CRMD);
        read_csr(CSR_PRMD);
    endtask

    task automatic test_priority_stall;
        branch_req_t b0;
        branch_req_t b1;
        b0 = make_branch(1'b1, 32'h1c00_4000, 3'd1);
        b1 = make_branch(1'b1, 32'h1c00_5000, 3'd4);
        flush_cycle(make_event(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 6'h0, 9'h0, 32'h1c00_3000, 3'd3),
                    b0, b1, 1'b0);
        flush_cycle(make_event(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 6'h0, 9'h0, 32'h1c00_3010, 3'd7),
                    b0, b1, 1'b0);
        flush_cycle(make_event(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, ECODE_BRK, 9'h0, 32'h1c00_3020,
                               3'd2), b0, b1, 1'b0);
        flush_cycle('0, b0, b1, 1'b0);
        flush_cycle('0, '0, b1, 1'b0);
        flush_cycle('0, b0, b1, 1'b1);  // Held by execute
        flush_cycle(make_event(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 6'h0, 9'h0, 32'h1c00_3030, 3'd0),
                    b0, b1, 1'b1);
    endtask

    task automatic test_csr_write_rules;
        csr_write(make_csr_wr(CSR_SAVE0, 32'h1111_2222), make_csr_wr(CSR_SAVE0, 32'h3333_4444));
        read_csr(CSR_SAVE0);
        csr_write(make_csr_wr(CSR_ESTAT, 32'hffff_ffff), '0);
        read_csr(CSR_ESTAT);
        csr_write(make_csr_wr(CSR_EENTRY, 32'hffff_ffff),
                  make_csr_wr(CSR_TLBRENTRY, 32'h1234_567f));
        read_csr(CSR_EENTRY);
        read_csr(CSR_TLBRENTRY);
        read_csr(14'h3ff);
        read_csr(14'h2);
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed          = 32'h1563;
        error_count   = 0;
        check_count   = 0;
        reset_i       = 1'b1;
        // Valid slots held through reset so the trace has to clear
        commit_i[0]   = make_slot(1'b1, 1'b0, 5'd1, 32'h0123_4567, 32'h1c00_0000, 3'd0);
        commit_i[1]   = make_slot(1'b1, 1'b0, 5'd2, 32'h89ab_cdef, 32'h1c00_0004, 3'd0);
        excp_i        = '0;
        branch_i      = '0;
        ex_stall_i    = 1'b0;
        csr_wr_i      = '0;
        csr_raddr_i   = '0;
        reg_raddr_i   = '0;
        ref_regs[0]   = '0;  // r0 never takes a write
        ref_crmd      = '0;
        ref_prmd      = '0;
        ref_ecode     = '0;
        ref_esubcode  = '0;
        ref_era       = '0;
        ref_eentry    = '0;
        ref_tlbrentry = '0;
        ref_save0     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i  = 1'b0;
        commit_i = '0;
        check_after_reset();
        test_reg_write_read();
        test_trace();
        test_exception_entry();
        test_ertn();
        test_priority_stall();
        test_csr_write_rules();
        next_cycle();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/backend_commit_top.sv
`timescale 1ns/1ps
`default_nettype none

module backend_commit_top #(
    parameter int NUM_READ_PORTS = 4
) (
    input  wire logic                                                          clk,
    input  wire logic                                                          reset_i,
    input  wire core_cfg_pkg::commit_slot_t [core_cfg_pkg::COMMIT_WIDTH-1:0]   commit_i,
    input  wire csr_pkg::excp_event_t                                          excp_i,
    input  wire core_cfg_pkg::branch_req_t [core_cfg_pkg::COMMIT_WIDTH-1:0]    branch_i,
    input  wire logic                                                          ex_stall_i,
    input  wire csr_pkg::csr_wr_t [core_cfg_pkg::COMMIT_WIDTH-1:0]             csr_wr_i,
    input  wire logic [csr_pkg::CSR_ADDR_W-1:0]                                csr_raddr_i,
    input  wire logic [NUM_READ_PORTS-1:0][core_cfg_pkg::REG_ADDR_W-1:0]       reg_raddr_i,
    output core_cfg_pkg::redirect_t                                            redirect_o,
    output logic [core_cfg_pkg::XLEN-1:0]                                      csr_rdata_o,
    output logic [NUM_READ_PORTS-1:0][core_cfg_pkg::XLEN-1:0]                  reg_rdata_o,
    output core_cfg_pkg::commit_slot_t [core_cfg_pkg::COMMIT_WIDTH-1:0]        trace_o
);
    import core_cfg_pkg::*;
    import csr_pkg::*;

    // CSR file to redirect control
    logic [XLEN-1:0] csr_era;
    logic [XLEN-1:0] csr_eentry;
    logic [XLEN-1:0] csr_tlbrentry;

    // Redirect control to CSR file
    trap_kind_e      trap_kind;
    excp_event_t     trap_event;

    redirect_ctrl u_redirect_ctrl (
        .excp_i      (excp_i),
        .branch_i    (branch_i),
        .ex_stall_i  (ex_stall_i),
        .era_i       (csr_era),
        .eentry_i    (csr_eentry),
        .tlbrentry_i (csr_tlbrentry),
        .redirect_o  (redirect_o),
        .trap_kind_o (trap_kind),
        .trap_event_o(trap_event)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .reset_i     (reset_i),
        .trap_kind_i (trap_kind),
        .trap_event_i(trap_event),
        .csr_wr_i    (csr_wr_i),
        .csr_raddr_i (csr_raddr_i),
        .csr_rdata_o (csr_rdata_o),
        .era_o       (csr_era),
        .eentry_o    (csr_eentry),
        .tlbrentry_o (csr_tlbrentry)
    );

    regfile #(
        .NUM_READ_PORTS(NUM_READ_PORTS)
    ) u_regfile (
        .clk     (clk),
        .commit_i(commit_i),
        .raddr_i (reg_raddr_i),
        .rdata_o (reg_rdata_o)
    );

    commit_trace u_commit_trace (
        .clk     (clk),
        .reset_i (reset_i),
        .commit_i(commit_i),
        .trace_o (trace_o)
    );

endmodule

`default_nettype wire

// File: verilog/commit_trace.sv
`timescale 1ns/1ps
`default_nettype none

module commit_trace (
    input  wire logic                                                        clk,
    input  wire logic                                                        reset_i,
    input  wire core_cfg_pkg::commit_slot_t [core_cfg_pkg::COMMIT_WIDTH-1:0] commit_i,
    output core_cfg_pkg::commit_slot_t [core_cfg_pkg::COMMIT_WIDTH-1:0]      trace_o
);
    import core_cfg_pkg::*;

    commit_slot_t [COMMIT_WIDTH-1:0] trace_d;

    // Idle slots show as all zero on the trace
    for (genvar s = 0; s < COMMIT_WIDTH; s++) begin : g_mask
        assign trace_d[s] = commit_i[s].valid ? commit_i[s] : '0;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            trace_o <= '0;
        end else begin
            trace_o <= trace_d;  // One cycle behind commit
        end
    end

endmodule

`default_nettype wire

// File: verilog/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

    localparam int XLEN         = 32;
    localparam int REG_ADDR_W   = 5;
    localparam int COMMIT_WIDTH = 2;  // Commit and execute slots
    localparam int FTQ_ID_W     = 3;

    // One retiring instruction
    typedef struct packed {
        logic                  valid;
        logic                  we;      // Writes the register file
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       pc;
        logic [FTQ_ID_W-1:0]   ftq_id;
    } commit_slot_t;

    // Resolved branch from one execute slot
    typedef struct packed {
        logic                taken;
        logic [XLEN-1:0]     target;
        logic [FTQ_ID_W-1:0] ftq_id;
    } branch_req_t;

    // Frontend redirect
    typedef struct packed {
        logic                flush;
        logic [XLEN-1:0]     next_pc;
        logic [FTQ_ID_W-1:0] ftq_id;
    } redirect_t;

endpackage

`default_nettype wire

// File: verilog/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire logic                                                 clk,
    input  wire logic                                                 reset_i,
    input  wire csr_pkg::trap_kind_e                                  trap_kind_i,
    input  wire csr_pkg::excp_event_t                                 trap_event_i,
    input  wire csr_pkg::csr_wr_t [core_cfg_pkg::COMMIT_WIDTH-1:0]    csr_wr_i,
    input  wire logic [csr_pkg::CSR_ADDR_W-1:0]                       csr_raddr_i,
    output logic [core_cfg_pkg::XLEN-1:0]                             csr_rdata_o,
    output logic [core_cfg_pkg::XLEN-1:0]                             era_o,
    output logic [core_cfg_pkg::XLEN-1:0]                             eentry_o,
    output logic [core_cfg_pkg::XLEN-1:0]                             tlbrentry_o
);
    import core_cfg_pkg::*;
    import csr_pkg::*;

    localparam int ENTRY_LSB = 6;  // Entry vectors are 64-byte aligned

    // Software-writable registers
    localparam int W_CRMD      = 0;
    localparam int W_PRMD      = 1;
    localparam int W_ERA       = 2;
    localparam int W_EENTRY    = 3;
    localparam int W_TLBRENTRY = 4;
    localparam int W_SAVE0     = 5;
    localparam int NUM_WREG    = 6;

    crmd_t                         crmd_q;
    crmd_t                         prmd_q;     // pplv and pie
    logic [ECODE_W-1:0]            ecode_q;
    logic [ESUBCODE_W-1:0]         esubcode_q;
    logic [XLEN-1:0]               era_q;
    logic [XLEN-1:ENTRY_LSB]       eentry_q;
    logic [XLEN-1:ENTRY_LSB]       tlbrentry_q;
    logic [XLEN-1:0]               save0_q;

    logic [NUM_WREG-1:0]           wr_hit;
    logic [NUM_WREG-1:0][XLEN-1:0] wr_data;
    logic                          trap_excp;
    logic                          trap_ertn;

    // ESTAT and unknown addresses give -1
    function automatic int wreg_index(input logic [CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_CRMD:      return W_CRMD;
            CSR_PRMD:      return W_PRMD;
            CSR_ERA:       return W_ERA;
            CSR_EENTRY:    return W_EENTRY;
            CSR_TLBRENTRY: return W_TLBRENTRY;
            CSR_SAVE0:     return W_SAVE0;
            default:       return -1;
        endcase
    endfunction

    // Later slot overwrites, so slot 1 wins a shared address
    always_comb begin
        int idx;
        wr_hit  = '0;
        wr_data = '0;
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            idx = wreg_index(csr_wr_i[i].addr);
            if (csr_wr_i[i].we && idx >= 0) begin
                wr_hit[idx]  = 1'b1;
                wr_data[idx] = csr_wr_i[i].data;
            end
        end
    end

    assign trap_excp = (trap_kind_i == TRAP_EXCP);
    assign trap_ertn = (trap_kind_i == TRAP_ERTN);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            crmd_q      <= '0;
            prmd_q      <= '0;
            ecode_q     <= '0;
            esubcode_q  <= '0;
            era_q       <= '0;
            eentry_q    <= '0;
            tlbrentry_q <= '0;
            save0_q     <= '0;
        end else begin
            // Trap updates take priority over software writes
            if (trap_excp) begin
                crmd_q <= '0;  // Kernel mode, interrupts off
            end else if (trap_ertn) begin
                crmd_q <= prmd_q;
            end else if (wr_hit[W_CRMD]) begin
                crmd_q <= wr_data[W_CRMD][$bits(crmd_t)-1:0];
            end

            if (trap_excp) begin
                prmd_q <= crmd_q;
            end else if (wr_hit[W_PRMD]) begin
                prmd_q <= wr_data[W_PRMD][$bits(crmd_t)-1:0];
            end

            if (trap_excp) begin
                era_q      <= trap_event_i.pc;
                ecode_q    <= trap_event_i.ecode;
                esubcode_q <= trap_event_i.esubcode;
            end else if (wr_hit[W_ERA]) begin
                era_q <= wr_data[W_ERA];
            end

            if (wr_hit[W_EENTRY]) begin
                eentry_q <= wr_data[W_EENTRY][XLEN-1:ENTRY_LSB];
            end
            if (wr_hit[W_TLBRENTRY]) begin
                tlbrentry_q <= wr_data[W_TLBRENTRY][XLEN-1:ENTRY_LSB];
            end
            if (wr_hit[W_SAVE0]) begin
                save0_q <= wr_data[W_SAVE0];
            end
        end
    end

    assign era_o       = era_q;
    assign eentry_o    = {eentry_q, {ENTRY_LSB{1'b0}}};
    assign tlbrentry_o = {tlbrentry_q, {ENTRY_LSB{1'b0}}};

    always_comb begin
        case (csr_raddr_i)
            CSR_CRMD:      csr_rdata_o = XLEN'(crmd_q);
            CSR_PRMD:      csr_rdata_o = XLEN'(prmd_q);
            CSR_ESTAT:     csr_rdata_o = XLEN'({esubcode_q, ecode_q, 16'b0});  // Bits 30:16
            CSR_ERA:       csr_rdata_o = era_o;
            CSR_EENTRY:    csr_rdata_o = eentry_o;
            CSR_TLBRENTRY: csr_rdata_o = tlbrentry_o;
            CSR_SAVE0:     csr_rdata_o = save0_q;
            default:       csr_rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;

    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD      = 14'h0;
    localparam logic [CSR_ADDR_W-1:0] CSR_PRMD      = 14'h1;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT     = 14'h5;
    localparam logic [CSR_ADDR_W-1:0] CSR_ERA       = 14'h6;
    localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY    = 14'hc;
    localparam logic [CSR_ADDR_W-1:0] CSR_SAVE0     = 14'h30;
    localparam logic [CSR_ADDR_W-1:0] CSR_TLBRENTRY = 14'h88;

    localparam logic [ECODE_W-1:0] ECODE_SYS  = 6'h0b;
    localparam logic [ECODE_W-1:0] ECODE_BRK  = 6'h0c;
    localparam logic [ECODE_W-1:0] ECODE_INE  = 6'h0d;
    localparam logic [ECODE_W-1:0] ECODE_TLBR = 6'h3f;

    typedef enum logic [1:0] {
        TRAP_NONE = 2'd0,
        TRAP_EXCP = 2'd1,
        TRAP_ERTN = 2'd2
    } trap_kind_e;

    // Raised by the oldest commit slot
    typedef struct packed {
        logic                              excp;
        logic                              ertn;
        logic                              idle;
        logic                              refetch;
        logic                              tlbrefill;
        logic [ECODE_W-1:0]                ecode;
        logic [ESUBCODE_W-1:0]             esubcode;
        logic [core_cfg_pkg::XLEN-1:0]     pc;
        logic [core_cfg_pkg::FTQ_ID_W-1:0] ftq_id;
    } excp_event_t;

    typedef struct packed {
        logic                          we;
        logic [CSR_ADDR_W-1:0]         addr;
        logic [core_cfg_pkg::XLEN-1:0] data;
    } csr_wr_t;

    // Bit 2 is ie, bits 1:0 are plv, as in the CRMD word
    typedef struct packed {
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

endpackage

`default_nettype wire

// File: verilog/redirect_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module redirect_ctrl (
    input  wire csr_pkg::excp_event_t                                       excp_i,
    input  wire core_cfg_pkg::branch_req_t [core_cfg_pkg::COMMIT_WIDTH-1:0] branch_i,
    input  wire logic                                                       ex_stall_i,
    input  wire logic [core_cfg_pkg::XLEN-1:0]                              era_i,
    input  wire logic [core_cfg_pkg::XLEN-1:0]                              eentry_i,
    input  wire logic [core_cfg_pkg::XLEN-1:0]                              tlbrentry_i,
    output core_cfg_pkg::redirect_t                                         redirect_o,
    output csr_pkg::trap_kind_e                                             trap_kind_o,
    output csr_pkg::excp_event_t                                            trap_event_o
);
    import core_cfg_pkg::*;
    import csr_pkg::*;

    logic [COMMIT_WIDTH-1:0] br_take;  // Taken and not held by execute
    logic                    br_any;
    logic [XLEN-1:0]         br_pc;
    logic [FTQ_ID_W-1:0]     br_ftq;
    logic                    sys_flush;  // Any of the commit-side causes
    logic [XLEN-1:0]         sys_pc;

    // Execute may still be waiting on operands while stalled
    always_comb begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            br_take[i] = branch_i[i].taken & ~ex_stall_i;
        end
    end

    // Lowest slot is oldest, scan down so it lands last
    always_comb begin
        br_pc  = '0;
        br_ftq = '0;
        for (int i = COMMIT_WIDTH - 1; i >= 0; i--) begin
            if (br_take[i]) begin
                br_pc  = branch_i[i].target;
                br_ftq = branch_i[i].ftq_id;
            end
        end
    end

    assign br_any    = |br_take;
    assign sys_flush = excp_i.excp | excp_i.ertn | excp_i.idle | excp_i.refetch;

    always_comb begin
        if (excp_i.excp) begin
            sys_pc = excp_i.tlbrefill ? tlbrentry_i : eentry_i;
        end else if (excp_i.ertn) begin
            sys_pc = era_i;
        end else if (excp_i.idle) begin
            sys_pc = excp_i.pc;                 // Re-execute idle on wake-up
        end else begin
            sys_pc = excp_i.pc + XLEN'(4);      // Refetch the next instruction
        end
    end

    always_comb begin
        redirect_o = '0;
        if (sys_flush) begin
            redirect_o.flush   = 1'b1;
            redirect_o.next_pc = sys_pc;
            redirect_o.ftq_id  = excp_i.ftq_id;
        end else if (br_any) begin
            redirect_o.flush   = 1'b1;
            redirect_o.next_pc = br_pc;
            redirect_o.ftq_id  = br_ftq;
        end
    end

    // Only exception entry and ertn touch the CSRs
    always_comb begin
        if (excp_i.excp) begin
            trap_kind_o = TRAP_EXCP;
        end else if (excp_i.ertn) begin
            trap_kind_o = TRAP_ERTN;
        end else begin
            trap_kind_o = TRAP_NONE;
        end
    end

    assign trap_event_o = (trap_kind_o == TRAP_NONE) ? '0 : excp_i;

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile #(
    parameter int NUM_READ_PORTS = 4
) (
    input  wire logic                                                     clk,
    input  wire core_cfg_pkg::commit_slot_t [core_cfg_pkg::COMMIT_WIDTH-1:0] commit_i,
    input  wire logic [NUM_READ_PORTS-1:0][core_cfg_pkg::REG_ADDR_W-1:0]  raddr_i,
    output logic [NUM_READ_PORTS-1:0][core_cfg_pkg::XLEN-1:0]             rdata_o
);
    import core_cfg_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    // Slot 1 is scheduled last and wins a shared index
    always_ff @(posedge clk) begin
        for (int i = 0; i < COMMIT_WIDTH; i++) begin
            if (commit_i[i].valid && commit_i[i].we && commit_i[i].waddr != '0) begin
                regs[commit_i[i].waddr] <= commit_i[i].wdata;
            end
        end
    end

    // No write-to-read bypass
    for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_read
        assign rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];  // r0 hardwired
    end

endmodule

`default_nettype wire
